// File: nebula_ii.f
verilog/nebula_pkg.sv
verilog/wb_if.sv
verilog/wb_arbiter.sv
verilog/wb_decoder.sv
verilog/wb_sram.sv
verilog/gpio_select.sv
verilog/la_select.sv
verilog/sample_project.sv
verilog/nebula_ii.sv
verification/nebula_ii_assertions.sv
verification/nebula_ii_tb.sv

// File: verification/nebula_ii_assertions.sv
// Concurrent checks on the host Wishbone port and pin enables
`default_nettype none

module nebula_ii_assertions (
    input wire                         clk_i,
    input wire                         rst_n_i,
    input wire                         cyc_i,
    input wire                         stb_i,
    input wire                         ack_i,
    input wire nebula_pkg::gpio_word_t io_oeb_i
);
    import nebula_pkg::*;

    int fail_count = 0;     // Failed property count

    property p_ack_with_strobe;
        @(posedge clk_i) disable iff (!rst_n_i) ack_i |-> (cyc_i && stb_i);
    endproperty

    property p_ack_single;
        @(posedge clk_i) disable iff (!rst_n_i) ack_i |=> !ack_i;
    endproperty

    // All pins are inputs during reset
    property p_oeb_in_reset;
        @(posedge clk_i) !rst_n_i |-> (io_oeb_i == {GPIO_W{1'b1}});
    endproperty

    a_ack_with_strobe: assert property (p_ack_with_strobe) else begin
        $error("host ack seen without cyc and stb");
        fail_count++;
    end

    a_ack_single: assert property (p_ack_single) else begin
        $error("host ack held for two cycles");
        fail_count++;
    end

    a_oeb_in_reset: assert property (p_oeb_in_reset) else begin
        $error("io_oeb not all ones during reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: verification/nebula_ii_tb.sv
// Testbench with clock, reset, host bus tasks, reference models and watchdog
// Covers SRAM, registers, pin and LA routing, project transfers and unmapped accesses
`default_nettype none

module nebula_ii_tb;
    import nebula_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_STEPS    = 7;
    localparam int          STEP_CYCLES  = 400;
    localparam int          SRAM_TESTS   = 16;
    localparam logic [31:0] LCG_SEED     = 32'd47333;

    logic             clk;
    logic             rst_n;
    logic             wbs_cyc;
    logic             wbs_stb;
    logic             wbs_we;
    logic [SEL_W-1:0] wbs_sel;
    logic [DAT_W-1:0] wbs_dat_w;
    logic [ADR_W-1:0] wbs_adr;
    logic             wbs_ack;
    logic [DAT_W-1:0] wbs_dat_r;
    gpio_word_t       io_out;
    gpio_word_t       io_oeb;
    logic [LA_W-1:0]  la_out;

    logic [31:0]      lcg_state;
    logic [DAT_W-1:0] sram_ref [SRAM_WORDS];   // Byte-lane reference
    logic [7:0]       sram_idx [SRAM_TESTS];
    logic [31:0]      sel_lo_m;
    logic [5:0]       sel_hi_m;
    logic             en_m;
    logic [3:0]       la_sel_m;
    logic [31:0]      p_out_m   [NUM_PROJECTS];   // Low 32 pins only
    logic [31:0]      p_oeb_m   [NUM_PROJECTS];
    logic [31:0]      p_la_m    [NUM_PROJECTS];
    logic [31:0]      p_daddr_m [NUM_PROJECTS];
    logic [31:0]      p_ddata_m [NUM_PROJECTS];

    nebula_ii i_dut (
        .wb_clk_i      (clk),
        .rst_n_i       (rst_n),
        .wbs_stb_i     (wbs_stb),
        .wbs_cyc_i     (wbs_cyc),
        .wbs_we_i      (wbs_we),
        .wbs_sel_i     (wbs_sel),
        .wbs_dat_i     (wbs_dat_w),
        .wbs_adr_i     (wbs_adr),
        .wbs_ack_o     (wbs_ack),
        .wbs_dat_o     (wbs_dat_r),
        .io_out_o      (io_out),
        .io_oeb_o      (io_oeb),
        .la_data_out_o (la_out)
    );

    bind nebula_ii nebula_ii_assertions i_assertions (
        .clk_i    (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .cyc_i    (wbs_cyc_i),
        .stb_i    (wbs_stb_i),
        .ack_i    (wbs_ack_o),
        .io_oeb_i (io_oeb_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_STEPS * STEP_CYCLES));
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    // Bound property failures end the run at once
    initial begin
        wait (i_dut.i_assertions.fail_count != 0);
        $display("A bound assertion on the host bus or the pins failed");
        $display("Simulation FAILED");
        $fatal(1, "bound assertion failed");
    end

    function logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [ADR_W-1:0] make_adr(input logic [3:0] region,
                                                  input logic [7:0] off);
        return {REGION_TAG, region, 8'h00, off};
    endfunction

    function automatic logic [ADR_W-1:0] proj_adr(input int p, input logic [7:0] off);
        return make_adr((p == 0) ? PROJ0_REGION : PROJ1_REGION, off);
    endfunction

    function automatic logic [ADR_W-1:0] sram_adr(input logic [7:0] idx);
        return {REGION_TAG, SRAM_REGION, 6'd0, idx, 2'b00};
    endfunction

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // One classic cycle with stb dropped after the edge that samples ack
    task automatic host_access(input logic we, input logic [ADR_W-1:0] adr,
                               input logic [DAT_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                               output logic [DAT_W-1:0] rdat);
        @(negedge clk);
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_adr   = adr;
        wbs_dat_w = wdat;
        wbs_sel   = sel;
        do begin
            @(negedge clk);
        end while (!wbs_ack);
        rdat = wbs_dat_r;
        @(negedge clk);
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic host_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat,
                              input logic [SEL_W-1:0] sel);
        logic [DAT_W-1:0] unused;
        host_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic host_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] dat);
        host_access(1'b0, adr, '0, '1, dat);
    endtask

    task automatic read_expect(input string name, input logic [ADR_W-1:0] adr,
                               input logic [DAT_W-1:0] expected);
        logic [DAT_W-1:0] rd;
        host_read(adr, rd);
        check_equal(name, expected, rd);
    endtask

    task automatic check_all_registers(input string tag);
        read_expect({tag, " gpio sel lo"}, make_adr(GPIO_REGION, GPIO_SEL_LO), sel_lo_m);
        read_expect({tag, " gpio sel hi"}, make_adr(GPIO_REGION, GPIO_SEL_HI), sel_hi_m);
        read_expect({tag, " gpio enable"}, make_adr(GPIO_REGION, GPIO_ENABLE), en_m);
        read_expect({tag, " la sel"}, make_adr(LA_REGION, LA_SEL), la_sel_m);
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            read_expect($sformatf("%s p%0d gpio out", tag, p),
                        proj_adr(p, PROJ_GPIO_OUT), p_out_m[p]);
            read_expect($sformatf("%s p%0d gpio oeb", tag, p),
                        proj_adr(p, PROJ_GPIO_OEB), p_oeb_m[p]);
            read_expect($sformatf("%s p%0d la out", tag, p), proj_adr(p, PROJ_LA_OUT), p_la_m[p]);
            read_expect($sformatf("%s p%0d dma addr", tag, p),
                        proj_adr(p, PROJ_DMA_ADDR), p_daddr_m[p]);
            read_expect($sformatf("%s p%0d dma data", tag, p),
                        proj_adr(p, PROJ_DMA_DATA), p_ddata_m[p]);
            read_expect($sformatf("%s p%0d busy", tag, p), proj_adr(p, PROJ_START), 32'd0);
        end
    endtask

    task automatic check_pins_idle(input string tag);
        check_equal({tag, " io_oeb"}, {GPIO_W{1'b1}}, io_oeb);
        check_equal({tag, " io_out"}, '0, io_out);
    endtask

    task automatic test_readback();
        logic [31:0] d;
        sel_lo_m = rand_word();
        host_write(make_adr(GPIO_REGION, GPIO_SEL_LO), sel_lo_m, 4'hF);
        d = rand_word();
        host_write(make_adr(GPIO_REGION, GPIO_SEL_HI), d, 4'hF);
        sel_hi_m = d[5:0];      // Six upper pins
        d = rand_word();
        host_write(make_adr(GPIO_REGION, GPIO_ENABLE), d, 4'hF);
        en_m = d[0];
        d = rand_word();
        host_write(make_adr(LA_REGION, LA_SEL), d, 4'hF);
        la_sel_m = d[3:0];
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            p_out_m[p]   = rand_word();
            p_oeb_m[p]   = rand_word();
            p_la_m[p]    = rand_word();
            p_daddr_m[p] = rand_word();
            p_ddata_m[p] = rand_word();
            host_write(proj_adr(p, PROJ_GPIO_OUT), p_out_m[p], 4'hF);
            host_write(proj_adr(p, PROJ_GPIO_OEB), p_oeb_m[p], 4'hF);
            host_write(proj_adr(p, PROJ_LA_OUT), p_la_m[p], 4'hF);
            host_write(proj_adr(p, PROJ_DMA_ADDR), p_daddr_m[p], 4'hF);
            host_write(proj_adr(p, PROJ_DMA_DATA), p_ddata_m[p], 4'hF);
        end
        check_all_registers("readback");
    endtask

    task automatic test_sram();
        int          j;
        logic [31:0] d;
        logic [3:0]  sel;
        for (int i = 0; i < SRAM_TESTS; i++) begin
            d           = rand_word();
            sram_idx[i] = {1'b0, d[6:0]};   // Upper words left for transfers
            d           = rand_word();
            host_write(sram_adr(sram_idx[i]), d, 4'hF);
            sram_ref[sram_idx[i]] = d;
        end
        for (int i = 0; i < SRAM_TESTS; i++) begin
            j   = rand_word() % SRAM_TESTS;
            d   = rand_word();
            sel = rand_word();
            host_write(sram_adr(sram_idx[j]), d, sel);
            for (int b = 0; b < SEL_W; b++) begin
                if (sel[b]) sram_ref[sram_idx[j]][b*8 +: 8] = d[b*8 +: 8];
            end
        end
        for (int i = 0; i < SRAM_TESTS; i++) begin
            read_expect($sformatf("sram word %0d", sram_idx[i]), sram_adr(sram_idx[i]),
                        sram_ref[sram_idx[i]]);
        end
    endtask

    task automatic test_gpio_routing();
        logic [31:0] d;
        gpio_word_t  sel_m;
        gpio_word_t  out_w [NUM_PROJECTS];
        gpio_word_t  oeb_w [NUM_PROJECTS];
        gpio_word_t  exp_out;
        gpio_word_t  exp_oeb;
        repeat (4) begin
            for (int p = 0; p < NUM_PROJECTS; p++) begin
                p_out_m[p] = rand_word();
                p_oeb_m[p] = rand_word();
                host_write(proj_adr(p, PROJ_GPIO_OUT), p_out_m[p], 4'hF);
                host_write(proj_adr(p, PROJ_GPIO_OEB), p_oeb_m[p], 4'hF);
            end
            sel_lo_m = rand_word();
            host_write(make_adr(GPIO_REGION, GPIO_SEL_LO), sel_lo_m, 4'hF);
            d = rand_word();
            host_write(make_adr(GPIO_REGION, GPIO_SEL_HI), d, 4'hF);
            sel_hi_m = d[5:0];
            host_write(make_adr(GPIO_REGION, GPIO_ENABLE), 32'd1, 4'hF);
            en_m = 1'b1;
            @(negedge clk);
            sel_m = {sel_hi_m, sel_lo_m};
            for (int p = 0; p < NUM_PROJECTS; p++) begin
                out_w[p] = GPIO_W'(p_out_m[p]);     // Upper pins written as zero
                oeb_w[p] = GPIO_W'(p_oeb_m[p]);
            end
            for (int i = 0; i < GPIO_W; i++) begin
                exp_out[i] = sel_m[i] ? out_w[1][i] : out_w[0][i];
                exp_oeb[i] = sel_m[i] ? oeb_w[1][i] : oeb_w[0][i];
            end
            check_equal("gpio routed out", exp_out, io_out);
            check_equal("gpio routed oeb", exp_oeb, io_oeb);
        end
        host_write(make_adr(GPIO_REGION, GPIO_ENABLE), 32'd0, 4'hF);
        en_m = 1'b0;
        @(negedge clk);
        check_pins_idle("gpio disabled");
    endtask

    task automatic test_la_routing();
        logic [31:0] exp;
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            p_la_m[p] = rand_word();
            host_write(proj_adr(p, PROJ_LA_OUT), p_la_m[p], 4'hF);
        end
        for (int s = 0; s < 16; s++) begin
            host_write(make_adr(LA_REGION, LA_SEL), s, 4'hF);
            la_sel_m = s;
            @(negedge clk);
            for (int b = 0; b < LA_BANKS; b++) begin
                exp = la_sel_m[b] ? p_la_m[1] : p_la_m[0];
                check_equal($sformatf("la sel %0d bank %0d", s, b), exp, la_out[b*32 +: 32]);
            end
        end
    endtask

    task automatic test_contention();
        logic [7:0]  dst [NUM_PROJECTS];
        logic [31:0] rd;
        int          j;
        dst[0] = 8'hF0;
        dst[1] = 8'hF1;
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            p_daddr_m[p] = sram_adr(dst[p]);
            p_ddata_m[p] = rand_word();
            host_write(proj_adr(p, PROJ_DMA_ADDR), p_daddr_m[p], 4'hF);
            host_write(proj_adr(p, PROJ_DMA_DATA), p_ddata_m[p], 4'hF);
        end
        host_write(proj_adr(0, PROJ_START), 32'd1, 4'hF);
        host_write(proj_adr(1, PROJ_START), 32'd1, 4'hF);
        for (int i = 0; i < 8; i++) begin     // Host traffic while projects write
            j = rand_word() % SRAM_TESTS;
            read_expect("sram during transfer", sram_adr(sram_idx[j]), sram_ref[sram_idx[j]]);
        end
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            do begin
                host_read(proj_adr(p, PROJ_START), rd);
            end while (rd[0]);
            sram_ref[dst[p]] = p_ddata_m[p];
            read_expect($sformatf("p%0d transfer word", p), sram_adr(dst[p]), p_ddata_m[p]);
        end
    endtask

    task automatic test_unmapped();
        read_expect("unmapped tag read", {12'h301, SRAM_REGION, 16'h0000}, 32'd0);
        read_expect("unmapped region read", make_adr(4'd5, 8'h00), 32'd0);
        host_write({12'h200, GPIO_REGION, 16'h0000}, rand_word(), 4'hF);
        host_write({12'h200, SRAM_REGION, 6'd0, sram_idx[0], 2'b00}, rand_word(), 4'hF);
        host_write(make_adr(4'd5, 8'h00), rand_word(), 4'hF);
        host_write({12'h301, PROJ0_REGION, 16'h0000}, rand_word(), 4'hF);
        read_expect("sram after unmapped write", sram_adr(sram_idx[0]), sram_ref[sram_idx[0]]);
        check_all_registers("unmapped");
    endtask

    initial begin
        lcg_state = LCG_SEED;
        rst_n     = 1'b0;
        wbs_cyc   = 1'b0;
        wbs_stb   = 1'b0;
        wbs_we    = 1'b0;
        wbs_sel   = '0;
        wbs_dat_w = '0;
        wbs_adr   = '0;
        sel_lo_m  = '0;
        sel_hi_m  = '0;
        en_m      = 1'b0;
        la_sel_m  = '0;
        for (int p = 0; p < NUM_PROJECTS; p++) begin
            p_out_m[p]   = '0;
            p_oeb_m[p]   = '1;  // Project pins reset as inputs
            p_la_m[p]    = '0;
            p_daddr_m[p] = '0;
            p_ddata_m[p] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_pins_idle("reset");
        check_equal("reset la out low", '0, la_out[63:0]);
        check_equal("reset la out high", '0, la_out[127:64]);
        check_all_registers("reset");
        test_readback();
        test_sram();
        test_gpio_routing();
        test_la_routing();
        test_contention();
        test_unmapped();

        @(negedge clk);
        if (i_dut.i_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "bound assertions reported errors");
        end
    end

endmodule

`default_nettype wire

// File: verilog/gpio_select.sv
// GPIO routing registers and per-pin project multiplexer
`default_nettype none

module gpio_select (
    input  wire                    wb_clk_i,
    input  wire                    rst_n_i,
    wb_if.target                   wb,
    input  wire nebula_pkg::gpio_word_t proj0_out_i,
    input  wire nebula_pkg::gpio_word_t proj0_oeb_i,
    input  wire nebula_pkg::gpio_word_t proj1_out_i,
    input  wire nebula_pkg::gpio_word_t proj1_oeb_i,
    output nebula_pkg::gpio_word_t io_out_o,
    output nebula_pkg::gpio_word_t io_oeb_o
);
    import nebula_pkg::*;

    logic [31:0]        sel_lo;
    logic [GPIO_W-33:0] sel_hi;     // Pins 32 and up
    logic               enable;
    logic               req;
    gpio_word_t         pin_sel;
    gpio_word_t         mux_out;
    gpio_word_t         mux_oeb;

    assign req = wb.cyc & wb.stb & ~wb.ack;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
            sel_lo <= '0;
            sel_hi <= '0;
            enable <= 1'b0;
        end else begin
            wb.ack <= req;
            if (req && wb.we) begin
                case (wb.adr[7:0])
                    GPIO_SEL_LO: sel_lo <= wb.dat_w;
                    GPIO_SEL_HI: sel_hi <= wb.dat_w[GPIO_W-33:0];
                    GPIO_ENABLE: enable <= wb.dat_w[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            case (wb.adr[7:0])
                GPIO_SEL_LO: wb.dat_r <= sel_lo;
                GPIO_SEL_HI: wb.dat_r <= DAT_W'(sel_hi);
                GPIO_ENABLE: wb.dat_r <= DAT_W'(enable);
                default:     wb.dat_r <= '0;
            endcase
        end
    end

    assign pin_sel = {sel_hi, sel_lo};
    assign mux_out = (proj1_out_i & pin_sel) | (proj0_out_i & ~pin_sel);
    assign mux_oeb = (proj1_oeb_i & pin_sel) | (proj0_oeb_i & ~pin_sel);

    // Disabled means every pin is an input
    assign io_out_o = enable ? mux_out : '0;
    assign io_oeb_o = enable ? mux_oeb : '1;

endmodule

`default_nettype wire

// File: verilog/la_select.sv
// Logic-analyzer bank select register and bank multiplexer
`default_nettype none

module la_select (
    input  wire                       wb_clk_i,
    input  wire                       rst_n_i,
    wb_if.target                      wb,
    input  wire nebula_pkg::la_word_t proj0_la_i,
    input  wire nebula_pkg::la_word_t proj1_la_i,
    output logic [nebula_pkg::LA_W-1:0] la_data_out_o
);
    import nebula_pkg::*;

    localparam int BANK_W = $bits(la_word_t);

    logic [LA_BANKS-1:0] bank_sel;  // 1 picks project 1
    logic                req;

    assign req = wb.cyc & wb.stb & ~wb.ack;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.ack   <= 1'b0;
            bank_sel <= '0;
        end else begin
            wb.ack <= req;
            if (req && wb.we && wb.adr[7:0] == LA_SEL) begin
                bank_sel <= wb.dat_w[LA_BANKS-1:0];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            wb.dat_r <= (wb.adr[7:0] == LA_SEL) ? DAT_W'(bank_sel) : '0;
        end
    end

    for (genvar b = 0; b < LA_BANKS; b++) begin : g_bank
        assign la_data_out_o[b*BANK_W +: BANK_W] = bank_sel[b] ? proj1_la_i : proj0_la_i;
    end

endmodule

`default_nettype wire

// File: verilog/nebula_ii.sv
// User-area top: host port, arbiter, decoder, SRAM, routing blocks
// and the two sample projects
`default_nettype none

module nebula_ii (
    input  wire                          wb_clk_i,
    input  wire                          rst_n_i,
    input  wire                          wbs_stb_i,
    input  wire                          wbs_cyc_i,
    input  wire                          wbs_we_i,
    input  wire [nebula_pkg::SEL_W-1:0]  wbs_sel_i,
    input  wire [nebula_pkg::DAT_W-1:0]  wbs_dat_i,
    input  wire [nebula_pkg::ADR_W-1:0]  wbs_adr_i,
    output logic                         wbs_ack_o,
    output logic [nebula_pkg::DAT_W-1:0] wbs_dat_o,
    output nebula_pkg::gpio_word_t       io_out_o,
    output nebula_pkg::gpio_word_t       io_oeb_o,
    output logic [nebula_pkg::LA_W-1:0]  la_data_out_o
);
    import nebula_pkg::*;

    gpio_word_t proj_gpio_out [NUM_PROJECTS];
    gpio_word_t proj_gpio_oeb [NUM_PROJECTS];
    la_word_t   proj_la_out   [NUM_PROJECTS];

    wb_if host_wb ();
    wb_if shared_wb ();
    wb_if proj_dma  [NUM_PROJECTS] ();
    wb_if sram_wb ();
    wb_if gpio_wb ();
    wb_if la_wb ();
    wb_if proj_regs [NUM_PROJECTS] ();

    // Host port onto its manager interface
    assign host_wb.cyc   = wbs_cyc_i;
    assign host_wb.stb   = wbs_stb_i;
    assign host_wb.we    = wbs_we_i;
    assign host_wb.adr   = wbs_adr_i;
    assign host_wb.dat_w = wbs_dat_i;
    assign host_wb.sel   = wbs_sel_i;
    assign wbs_ack_o     = host_wb.ack;
    assign wbs_dat_o     = host_wb.dat_r;

    wb_arbiter i_arbiter (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .mgr_host (host_wb),
        .mgr_p0   (proj_dma[0]),
        .mgr_p1   (proj_dma[1]),
        .bus      (shared_wb)
    );

    wb_decoder i_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .bus      (shared_wb),
        .t_sram   (sram_wb),
        .t_gpio   (gpio_wb),
        .t_la     (la_wb),
        .t_p0     (proj_regs[0]),
        .t_p1     (proj_regs[1])
    );

    wb_sram i_sram (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .wb       (sram_wb)
    );

    gpio_select i_gpio_select (
        .wb_clk_i    (wb_clk_i),
        .rst_n_i     (rst_n_i),
        .wb          (gpio_wb),
        .proj0_out_i (proj_gpio_out[0]),
        .proj0_oeb_i (proj_gpio_oeb[0]),
        .proj1_out_i (proj_gpio_out[1]),
        .proj1_oeb_i (proj_gpio_oeb[1]),
        .io_out_o    (io_out_o),
        .io_oeb_o    (io_oeb_o)
    );

    la_select i_la_select (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .wb            (la_wb),
        .proj0_la_i    (proj_la_out[0]),
        .proj1_la_i    (proj_la_out[1]),
        .la_data_out_o (la_data_out_o)
    );

    for (genvar p = 0; p < NUM_PROJECTS; p++) begin : g_proj
        sample_project i_project (
            .wb_clk_i   (wb_clk_i),
            .rst_n_i    (rst_n_i),
            .regs       (proj_regs[p]),
            .dma        (proj_dma[p]),
            .gpio_out_o (proj_gpio_out[p]),
            .gpio_oeb_o (proj_gpio_oeb[p]),
            .la_out_o   (proj_la_out[p])
        );
    end

endmodule

`default_nettype wire

// File: verilog/nebula_pkg.sv
// Bus widths, address map, register offsets and counts
// Named word types for pin and logic-analyzer buses
`default_nettype none

package nebula_pkg;

    localparam int ADR_W = 32;
    localparam int DAT_W = 32;
    localparam int SEL_W = 4;

    localparam int GPIO_W   = 38;
    localparam int LA_W     = 128;
    localparam int LA_BANKS = 4;

    localparam int NUM_PROJECTS = 2;
    localparam int NUM_MANAGERS = 3;    // Host plus one per project
    localparam int NUM_TARGETS  = 5;

    localparam logic [11:0] REGION_TAG = 12'h300;   // Carried on adr[31:20]

    // Region codes on adr[19:16]
    localparam logic [3:0] SRAM_REGION  = 4'd0;
    localparam logic [3:0] GPIO_REGION  = 4'd1;
    localparam logic [3:0] LA_REGION    = 4'd2;
    localparam logic [3:0] PROJ0_REGION = 4'd3;
    localparam logic [3:0] PROJ1_REGION = 4'd4;

    localparam int SRAM_WORDS = 256;

    localparam logic [7:0] GPIO_SEL_LO = 8'h00;    // Pins 0 to 31 where 1 picks project 1
    localparam logic [7:0] GPIO_SEL_HI = 8'h04;    // Pins 32 to 37
    localparam logic [7:0] GPIO_ENABLE = 8'h08;
    localparam logic [7:0] LA_SEL      = 8'h00;    // One bit per bank

    localparam logic [7:0] PROJ_GPIO_OUT = 8'h00;
    localparam logic [7:0] PROJ_GPIO_OEB = 8'h04;
    localparam logic [7:0] PROJ_LA_OUT   = 8'h08;
    localparam logic [7:0] PROJ_DMA_ADDR = 8'h0C;
    localparam logic [7:0] PROJ_DMA_DATA = 8'h10;
    localparam logic [7:0] PROJ_START    = 8'h14;  // Write starts and bit 0 reads busy

    typedef logic [GPIO_W-1:0]        gpio_word_t;
    typedef logic [LA_W/LA_BANKS-1:0] la_word_t;

endpackage

`default_nettype wire

// File: verilog/sample_project.sv
// Sample project register bank driving pin and LA words
// Issues one Wishbone write of its own per start command
`default_nettype none

module sample_project (
    input  wire   wb_clk_i,
    input  wire   rst_n_i,
    wb_if.target  regs,
    wb_if.manager dma,
    output nebula_pkg::gpio_word_t gpio_out_o,
    output nebula_pkg::gpio_word_t gpio_oeb_o,
    output nebula_pkg::la_word_t   la_out_o
);
    import nebula_pkg::*;

    logic [ADR_W-1:0] dma_addr;
    logic [DAT_W-1:0] dma_data;
    logic             busy;
    logic             dma_req;  // Drives cyc and stb
    logic             req;

    assign req = regs.cyc & regs.stb & ~regs.ack;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs.ack   <= 1'b0;
            gpio_out_o <= '0;
            gpio_oeb_o <= '1;   // Pins start as inputs
            la_out_o   <= '0;
            dma_addr   <= '0;
            dma_data   <= '0;
            busy       <= 1'b0;
            dma_req    <= 1'b0;
        end else begin
            regs.ack <= req;
            if (req && regs.we) begin
                case (regs.adr[7:0])
                    PROJ_GPIO_OUT: gpio_out_o <= GPIO_W'(regs.dat_w);
                    PROJ_GPIO_OEB: gpio_oeb_o <= GPIO_W'(regs.dat_w);
                    PROJ_LA_OUT:   la_out_o   <= regs.dat_w;
                    PROJ_DMA_ADDR: dma_addr   <= regs.dat_w;
                    PROJ_DMA_DATA: dma_data   <= regs.dat_w;
                    PROJ_START:    busy       <= 1'b1;
                    default: ;
                endcase
            end

            // Launch one edge after busy is set
            if (busy && !dma_req) begin
                dma_req <= 1'b1;
            end

            if (dma_req && dma.ack) begin
                dma_req <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            case (regs.adr[7:0])
                PROJ_GPIO_OUT: regs.dat_r <= DAT_W'(gpio_out_o);   // Low 32 pins only
                PROJ_GPIO_OEB: regs.dat_r <= DAT_W'(gpio_oeb_o);
                PROJ_LA_OUT:   regs.dat_r <= la_out_o;
                PROJ_DMA_ADDR: regs.dat_r <= dma_addr;
                PROJ_DMA_DATA: regs.dat_r <= dma_data;
                PROJ_START:    regs.dat_r <= DAT_W'(busy);
                default:       regs.dat_r <= '0;
            endcase
        end
    end

    assign dma.cyc   = dma_req;
    assign dma.stb   = dma_req;
    assign dma.we    = 1'b1;
    assign dma.adr   = dma_addr;
    assign dma.dat_w = dma_data;
    assign dma.sel   = '1;  // Full word

endmodule

`default_nettype wire

// File: verilog/wb_arbiter.sv
// Fixed-priority arbiter for host and two project managers
`default_nettype none

module wb_arbiter (
    input  wire   wb_clk_i,
    input  wire   rst_n_i,
    wb_if.target  mgr_host,
    wb_if.target  mgr_p0,
    wb_if.target  mgr_p1,
    wb_if.manager bus
);
    import nebula_pkg::*;

    localparam int IDX_W = $clog2(NUM_MANAGERS);

    logic [NUM_MANAGERS-1:0] req_cyc;
    logic [NUM_MANAGERS-1:0] req_stb;
    logic [NUM_MANAGERS-1:0] req_we;
    logic [ADR_W-1:0]        req_adr [NUM_MANAGERS];
    logic [DAT_W-1:0]        req_dat [NUM_MANAGERS];
    logic [SEL_W-1:0]        req_sel [NUM_MANAGERS];
    logic [IDX_W-1:0]        gnt;
    logic [IDX_W-1:0]        next_gnt;
    logic                    gnt_vld;
    logic [NUM_MANAGERS-1:0] own;   // One-hot owner

    // Index 0 is the host and has top priority
    assign req_cyc = {mgr_p1.cyc, mgr_p0.cyc, mgr_host.cyc};
    assign req_stb = {mgr_p1.stb, mgr_p0.stb, mgr_host.stb};
    assign req_we  = {mgr_p1.we, mgr_p0.we, mgr_host.we};

    assign req_adr = '{mgr_host.adr, mgr_p0.adr, mgr_p1.adr};
    assign req_dat = '{mgr_host.dat_w, mgr_p0.dat_w, mgr_p1.dat_w};
    assign req_sel = '{mgr_host.sel, mgr_p0.sel, mgr_p1.sel};

    always_comb begin
        next_gnt = '0;
        for (int i = NUM_MANAGERS - 1; i >= 0; i--) begin
            if (req_cyc[i]) begin
                next_gnt = IDX_W'(i);
            end
        end
    end

    // Owner keeps the bus until it drops cyc
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gnt_vld <= 1'b0;
            gnt     <= '0;
        end else if (!gnt_vld || !req_cyc[gnt]) begin
            gnt_vld <= |req_cyc;
            gnt     <= next_gnt;
        end
    end

    assign own = gnt_vld ? (NUM_MANAGERS'(1) << gnt) : '0;

    assign bus.cyc   = |(own & req_cyc);
    assign bus.stb   = |(own & req_stb);
    assign bus.we    = |(own & req_we);
    assign bus.adr   = req_adr[gnt];
    assign bus.dat_w = req_dat[gnt];
    assign bus.sel   = req_sel[gnt];

    assign mgr_host.ack   = own[0] & bus.ack;   // Waiting managers see no ack
    assign mgr_p0.ack     = own[1] & bus.ack;
    assign mgr_p1.ack     = own[2] & bus.ack;
    assign mgr_host.dat_r = own[0] ? bus.dat_r : '0;
    assign mgr_p0.dat_r   = own[1] ? bus.dat_r : '0;
    assign mgr_p1.dat_r   = own[2] ? bus.dat_r : '0;

endmodule

`default_nettype wire

// File: verilog/wb_decoder.sv
// Address decoder from the shared bus to five targets
// Unmapped accesses get a local zero-data ack
`default_nettype none

module wb_decoder (
    input  wire   wb_clk_i,
    input  wire   rst_n_i,
    wb_if.target  bus,
    wb_if.manager t_sram,
    wb_if.manager t_gpio,
    wb_if.manager t_la,
    wb_if.manager t_p0,
    wb_if.manager t_p1
);
    import nebula_pkg::*;

    logic                   tag_ok;
    logic [3:0]             region;
    logic [NUM_TARGETS-1:0] pick;
    logic [NUM_TARGETS-1:0] t_ack;
    logic [DAT_W-1:0]       t_dat [NUM_TARGETS];
    logic [DAT_W-1:0]       rd_mux;
    logic                   err_ack;

    assign tag_ok = (bus.adr[31:20] == REGION_TAG);
    assign region = bus.adr[19:16];

    assign pick[0] = tag_ok && (region == SRAM_REGION);
    assign pick[1] = tag_ok && (region == GPIO_REGION);
    assign pick[2] = tag_ok && (region == LA_REGION);
    assign pick[3] = tag_ok && (region == PROJ0_REGION);
    assign pick[4] = tag_ok && (region == PROJ1_REGION);

    // Only the picked target sees cyc and stb
    assign t_sram.cyc = bus.cyc & pick[0];
    assign t_sram.stb = bus.stb & pick[0];
    assign t_gpio.cyc = bus.cyc & pick[1];
    assign t_gpio.stb = bus.stb & pick[1];
    assign t_la.cyc   = bus.cyc & pick[2];
    assign t_la.stb   = bus.stb & pick[2];
    assign t_p0.cyc   = bus.cyc & pick[3];
    assign t_p0.stb   = bus.stb & pick[3];
    assign t_p1.cyc   = bus.cyc & pick[4];
    assign t_p1.stb   = bus.stb & pick[4];

    // Request payload goes to every target
    assign {t_sram.we, t_gpio.we, t_la.we, t_p0.we, t_p1.we} = {NUM_TARGETS{bus.we}};
    assign {t_sram.adr, t_gpio.adr, t_la.adr, t_p0.adr, t_p1.adr} = {NUM_TARGETS{bus.adr}};
    assign {t_sram.dat_w, t_gpio.dat_w, t_la.dat_w, t_p0.dat_w, t_p1.dat_w} =
        {NUM_TARGETS{bus.dat_w}};
    assign {t_sram.sel, t_gpio.sel, t_la.sel, t_p0.sel, t_p1.sel} = {NUM_TARGETS{bus.sel}};

    assign t_ack = {t_p1.ack, t_p0.ack, t_la.ack, t_gpio.ack, t_sram.ack};
    assign t_dat = '{t_sram.dat_r, t_gpio.dat_r, t_la.dat_r, t_p0.dat_r, t_p1.dat_r};

    always_comb begin
        rd_mux = '0;    // Unmapped reads return zero
        for (int i = 0; i < NUM_TARGETS; i++) begin
            if (pick[i]) begin
                rd_mux = t_dat[i];
            end
        end
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            err_ack <= 1'b0;
        end else begin
            err_ack <= bus.cyc && bus.stb && !(|pick) && !err_ack;
        end
    end

    assign bus.ack   = |(pick & t_ack) | err_ack;
    assign bus.dat_r = rd_mux;

endmodule

`default_nettype wire

// File: verilog/wb_if.sv
// Wishbone classic bus with manager and target views
`default_nettype none

interface wb_if;
    import nebula_pkg::*;

    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;    // Manager to target
    logic [SEL_W-1:0] sel;
    logic             ack;
    logic [DAT_W-1:0] dat_r;    // Target to manager

    modport manager (
        output cyc, stb, we, adr, dat_w, sel,
        input  ack, dat_r
    );

    modport target (
        input  cyc, stb, we, adr, dat_w, sel,
        output ack, dat_r
    );

endinterface

`default_nettype wire

// File: verilog/wb_sram.sv
// Byte-writable word SRAM behind a Wishbone target port
`default_nettype none

module wb_sram (
    input  wire  wb_clk_i,
    input  wire  rst_n_i,
    wb_if.target wb
);
    import nebula_pkg::*;

    localparam int IDX_W = $clog2(SRAM_WORDS);

    logic [DAT_W-1:0] mem [SRAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             req;

    assign idx = wb.adr[IDX_W+1:2];     // Word address
    assign req = wb.cyc & wb.stb & ~wb.ack;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= req;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req) begin
            if (wb.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (wb.sel[b]) begin
                        mem[idx][b*8 +: 8] <= wb.dat_w[b*8 +: 8];
                    end
                end
            end
            wb.dat_r <= mem[idx];   // Returned with the ack
        end
    end

endmodule

`default_nettype wire
